//--- Makefile
# Verilator build and run for the imuldiv unit

VERILATOR ?= verilator
TOP       ?= imuldiv_tb
RTL_TOP   ?= imuldiv_muldiv_iterative
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= imuldiv_sim
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)

run: build
	./$(BUILD_DIR)/$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "Testbench passed" $(LOG) || { echo "simulation FAILED, see $(LOG)"; exit 1; }
	@echo "simulation PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/imuldiv_defines.svh
// imuldiv width and iteration constants
// shared by the package and every engine of the multiply/divide unit

`ifndef IMULDIV_DEFINES_SVH
`define IMULDIV_DEFINES_SVH

// ------------------------------------------------------------
// datapath sizing
// ------------------------------------------------------------

// operand width of the processor
`define IMULDIV_XLEN 32

// one compute step per operand bit
`define IMULDIV_ITERS 32

// step counter width, wide enough to hold IMULDIV_ITERS
`define IMULDIV_CNT_W 6

`endif

//--- sim/imuldiv_tb.sv
// imuldiv testbench
// table-driven vectors, random response back-pressure and a per-engine scoreboard

`include "imuldiv_defines.svh"

module imuldiv_tb;

  localparam int MAX_VEC     = 32;
  localparam int STEP_CYCLES = 33;

  logic                       clk;
  logic                       reset;
  logic [1:0]                 req_fn;
  logic [`IMULDIV_XLEN-1:0]   req_a;
  logic [`IMULDIV_XLEN-1:0]   req_b;
  logic                       req_val;
  logic                       req_rdy;
  logic [2*`IMULDIV_XLEN-1:0] resp_result;
  logic                       resp_val;
  logic                       resp_rdy;

  // vector table
  string                      vec_name [MAX_VEC];
  imuldiv_pkg::fn_e           vec_fn   [MAX_VEC];
  logic [`IMULDIV_XLEN-1:0]   vec_a    [MAX_VEC];
  logic [`IMULDIV_XLEN-1:0]   vec_b    [MAX_VEC];
  imuldiv_pkg::resp_msg_t     vec_exp  [MAX_VEC];
  int                         num_vec;

  // scoreboard with one slot per engine
  logic                       mul_busy;
  logic                       div_busy;
  imuldiv_pkg::resp_msg_t     mul_exp;
  imuldiv_pkg::resp_msg_t     div_exp;
  string                      mul_name;
  string                      div_name;
  int                         resp_count;

  logic [15:0]                lfsr;
  bit                         table_ready;
  int                         watchdog_cycles;
  int                         i;

  imuldiv_muldiv_iterative dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  always #5 clk = ~clk;

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_resp(input string name, input imuldiv_pkg::resp_msg_t exp,
                            input imuldiv_pkg::resp_msg_t act);
    if (act !== exp) begin
      abort_run($sformatf("Error: %s expected %h actual %h", name, exp.result, act.result));
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic add_vector(input string name, input imuldiv_pkg::fn_e fn,
                            input logic [`IMULDIV_XLEN-1:0] a,
                            input logic [`IMULDIV_XLEN-1:0] b,
                            input logic [2*`IMULDIV_XLEN-1:0] result);
    vec_name[num_vec]       = name;
    vec_fn[num_vec]         = fn;
    vec_a[num_vec]          = a;
    vec_b[num_vec]          = b;
    vec_exp[num_vec].result = result;
    num_vec++;
  endtask

  // called just after a rising edge and returns just after the transfer edge
  task automatic issue_vector(input int idx);
    logic accepted;
    logic target_busy;
    accepted = 1'b0;
    req_fn   = vec_fn[idx];
    req_a    = vec_a[idx];
    req_b    = vec_b[idx];
    req_val  = 1'b1;
    while (!accepted) begin
      @(negedge clk);
      target_busy = (vec_fn[idx] == imuldiv_pkg::FN_MUL) ? mul_busy : div_busy;
      if (target_busy) begin
        // engine still owes a response and must not take a new request
        check_ready({vec_name[idx], " stall"}, 1'b0, req_rdy);
      end else if (req_rdy) begin
        if (vec_fn[idx] == imuldiv_pkg::FN_MUL) begin
          mul_busy = 1'b1;
          mul_exp  = vec_exp[idx];
          mul_name = vec_name[idx];
        end else begin
          div_busy = 1'b1;
          div_exp  = vec_exp[idx];
          div_name = vec_name[idx];
        end
        accepted = 1'b1;
      end
    end
    @(posedge clk);
    #1;
    req_val = 1'b0;
  endtask

  // transfer happens on the next rising edge
  task automatic take_response;
    imuldiv_pkg::resp_msg_t act;
    act.result = resp_result;
    if (mul_busy && act === mul_exp) begin
      mul_busy = 1'b0;
    end else if (div_busy && act === div_exp) begin
      div_busy = 1'b0;
    end else if (!mul_busy && !div_busy) begin
      abort_run("a response arrived with no operation outstanding");
    end else if (mul_busy) begin
      check_resp(mul_name, mul_exp, act);
    end else begin
      check_resp(div_name, div_exp, act);
    end
    resp_count++;
  endtask

  // ------------------------------------------------------------
  // back-pressure and response monitor
  // ------------------------------------------------------------

  always @(posedge clk) begin
    #1;
    lfsr     = lfsr_step(lfsr);
    resp_rdy = lfsr[0];
  end

  always @(negedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      take_response();
    end
  end

  // watchdog
  initial begin
    wait (table_ready);
    repeat (watchdog_cycles) @(posedge clk);
    abort_run("timeout: not every operation returned a response in time");
  end

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    req_fn      = imuldiv_pkg::FN_MUL;
    req_a       = '0;
    req_b       = '0;
    req_val     = 1'b0;
    resp_rdy    = 1'b0;
    lfsr        = 16'd26228;
    mul_busy    = 1'b0;
    div_busy    = 1'b0;
    resp_count  = 0;
    num_vec     = 0;
    table_ready = 1'b0;

    // divide results are {remainder, quotient}
    add_vector("divu 100/7", imuldiv_pkg::FN_DIVU, 32'd100, 32'd7, 64'h00000002_0000000e);
    add_vector("mul 3*-4", imuldiv_pkg::FN_MUL, 32'd3, 32'hfffffffc, 64'hffffffff_fffffff4);
    add_vector("divu 5/9", imuldiv_pkg::FN_DIVU, 32'd5, 32'd9, 64'h00000005_00000000);
    add_vector("mul 0*-1", imuldiv_pkg::FN_MUL, 32'd0, 32'hffffffff, 64'h0);
    add_vector("divu ones/16", imuldiv_pkg::FN_DIVU, 32'hffffffff, 32'd16,
               64'h0000000f_0fffffff);
    add_vector("mul -1*-1", imuldiv_pkg::FN_MUL, 32'hffffffff, 32'hffffffff, 64'h1);
    add_vector("divu 2^31/3", imuldiv_pkg::FN_DIVU, 32'h80000000, 32'd3,
               64'h00000002_2aaaaaaa);
    add_vector("mul min*min", imuldiv_pkg::FN_MUL, 32'h80000000, 32'h80000000,
               64'h40000000_00000000);
    add_vector("div 7/2", imuldiv_pkg::FN_DIV, 32'd7, 32'd2, 64'h00000001_00000003);
    add_vector("div -7/2", imuldiv_pkg::FN_DIV, 32'hfffffff9, 32'd2, 64'hffffffff_fffffffd);
    add_vector("mul max*min", imuldiv_pkg::FN_MUL, 32'h7fffffff, 32'h80000000,
               64'hc0000000_80000000);
    add_vector("div 7/-2", imuldiv_pkg::FN_DIV, 32'd7, 32'hfffffffe, 64'h00000001_fffffffd);
    add_vector("div -7/-2", imuldiv_pkg::FN_DIV, 32'hfffffff9, 32'hfffffffe,
               64'hffffffff_00000003);
    add_vector("mul max*max", imuldiv_pkg::FN_MUL, 32'h7fffffff, 32'h7fffffff,
               64'h3fffffff_00000001);
    add_vector("div min/-1", imuldiv_pkg::FN_DIV, 32'h80000000, 32'hffffffff,
               64'h00000000_80000000);
    add_vector("mul 2^16*-2^16", imuldiv_pkg::FN_MUL, 32'h00010000, 32'hffff0000,
               64'hffffffff_00000000);
    // zero divisor gives an all-ones quotient magnitude before the sign fix
    add_vector("divu 1234/0", imuldiv_pkg::FN_DIVU, 32'd1234, 32'd0, 64'h000004d2_ffffffff);
    add_vector("div -5/0", imuldiv_pkg::FN_DIV, 32'hfffffffb, 32'd0, 64'hfffffffb_00000001);
    add_vector("div 5/0", imuldiv_pkg::FN_DIV, 32'd5, 32'd0, 64'h00000005_ffffffff);

    // twice the serial latency plus slack for back-pressure
    watchdog_cycles = num_vec * STEP_CYCLES * 2 + 100;
    table_ready     = 1'b1;

    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    // idle state after reset
    @(negedge clk);
    check_ready("reset resp_val", 1'b0, resp_val);
    check_ready("reset req_rdy mul", 1'b1, req_rdy);
    @(posedge clk);
    #1;
    req_fn = imuldiv_pkg::FN_DIV;
    @(negedge clk);
    check_ready("reset req_rdy div", 1'b1, req_rdy);
    @(posedge clk);
    #1;

    for (i = 0; i < num_vec; i++) begin
      issue_vector(i);
    end

    wait (resp_count == num_vec);
    // a few idle cycles so a stray response would be caught
    repeat (5) @(posedge clk);

    $display("Testbench passed");
    $finish;
  end

endmodule

//--- src.f
+incdir+include
verilog/imuldiv_pkg.sv
verilog/imuldiv_req_dispatch.sv
verilog/imuldiv_mul_iterative.sv
verilog/imuldiv_div_iterative.sv
verilog/imuldiv_resp_arbiter.sv
verilog/imuldiv_muldiv_iterative.sv
sim/imuldiv_tb.sv

//--- verilog/imuldiv_div_iterative.sv
// imuldiv iterative divider
// 32-step restoring divide, signed or unsigned, remainder and quotient out

`include "imuldiv_defines.svh"

module imuldiv_div_iterative (
  input  logic                   clk,
  input  logic                   reset,

  input  imuldiv_pkg::req_msg_t  req_msg,
  input  logic                   req_val,
  output logic                   req_rdy,

  output imuldiv_pkg::resp_msg_t resp_msg,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  typedef enum logic [1:0] {IDLE, CALC, DONE} state_e;

  state_e                      state;
  logic [`IMULDIV_CNT_W-1:0]   count;
  logic                        req_go;
  logic                        resp_go;
  logic                        last_step;

  // operand handling at acceptance
  logic                        is_signed;
  logic                        a_neg;
  logic                        b_neg;
  logic [`IMULDIV_XLEN-1:0]    a_mag;
  logic [`IMULDIV_XLEN-1:0]    b_mag;

  // remainder in [64:32], quotient in [31:0]
  logic [2*`IMULDIV_XLEN:0]    rq;
  logic [`IMULDIV_XLEN-1:0]    divisor;
  logic                        quot_neg;
  logic                        rem_neg;

  // one restoring step
  logic [2*`IMULDIV_XLEN:0]    rq_shift;
  logic [2*`IMULDIV_XLEN:0]    rq_diff;
  logic [2*`IMULDIV_XLEN:0]    rq_next;

  // result halves
  logic [`IMULDIV_XLEN-1:0]    quot_mag;
  logic [`IMULDIV_XLEN-1:0]    rem_mag;
  logic [`IMULDIV_XLEN-1:0]    quot_out;
  logic [`IMULDIV_XLEN-1:0]    rem_out;

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  assign req_rdy   = (state == IDLE);
  assign resp_val  = (state == DONE);
  assign req_go    = req_val & req_rdy;
  assign resp_go   = resp_val & resp_rdy;
  assign last_step = (count == `IMULDIV_CNT_W'(`IMULDIV_ITERS - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          if (last_step) begin
            state <= DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        DONE: begin
          // hold the result until the arbiter takes it
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // operand setup
  // ------------------------------------------------------------

  // divu keeps raw bits, so no sign and no magnitude
  assign is_signed = (req_msg.fn == imuldiv_pkg::FN_DIV);
  assign a_neg     = is_signed & req_msg.a[`IMULDIV_XLEN-1];
  assign b_neg     = is_signed & req_msg.b[`IMULDIV_XLEN-1];
  assign a_mag     = a_neg ? -req_msg.a : req_msg.a;
  assign b_mag     = b_neg ? -req_msg.b : req_msg.b;

  // ------------------------------------------------------------
  // restoring step
  // ------------------------------------------------------------

  // divisor aligned at bit 32, a borrow shows up in bit 64
  assign rq_shift = rq << 1;
  assign rq_diff  = rq_shift - {1'b0, divisor, {`IMULDIV_XLEN{1'b0}}};

  always_comb begin
    if (rq_diff[2*`IMULDIV_XLEN]) begin
      // negative, restore and shift in a zero
      rq_next = {rq_shift[2*`IMULDIV_XLEN:1], 1'b0};
    end else begin
      rq_next = {rq_diff[2*`IMULDIV_XLEN:1], 1'b1};
    end
  end

  // zero divisor never borrows, so quotient ends all ones
  // and the remainder ends as the dividend magnitude
  always_ff @(posedge clk) begin
    if (req_go) begin
      rq       <= {{(`IMULDIV_XLEN+1){1'b0}}, a_mag};
      divisor  <= b_mag;
      quot_neg <= a_neg ^ b_neg;
      rem_neg  <= a_neg;
    end else if (state == CALC) begin
      rq <= rq_next;
    end
  end

  // ------------------------------------------------------------
  // sign fix
  // ------------------------------------------------------------

  assign quot_mag = rq[`IMULDIV_XLEN-1:0];
  assign rem_mag  = rq[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN];

  // remainder follows the dividend sign, not the quotient sign
  assign quot_out = quot_neg ? -quot_mag : quot_mag;
  assign rem_out  = rem_neg ? -rem_mag : rem_mag;

  assign resp_msg.result = {rem_out, quot_out};

endmodule

//--- verilog/imuldiv_mul_iterative.sv
// imuldiv iterative multiplier
// signed shift-add multiply over 32 steps, full 64-bit product

`include "imuldiv_defines.svh"

module imuldiv_mul_iterative (
  input  logic                   clk,
  input  logic                   reset,

  input  imuldiv_pkg::req_msg_t  req_msg,
  input  logic                   req_val,
  output logic                   req_rdy,

  output imuldiv_pkg::resp_msg_t resp_msg,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  typedef enum logic [1:0] {IDLE, CALC, DONE} state_e;

  state_e                      state;
  logic [`IMULDIV_CNT_W-1:0]   count;
  logic                        req_go;
  logic                        resp_go;
  logic                        last_step;

  // operand magnitudes taken at acceptance
  logic [`IMULDIV_XLEN-1:0]    a_mag;
  logic [`IMULDIV_XLEN-1:0]    b_mag;

  // working registers
  logic [2*`IMULDIV_XLEN-1:0]  mcand;
  logic [`IMULDIV_XLEN-1:0]    mplier;
  logic [2*`IMULDIV_XLEN-1:0]  acc;
  logic                        prod_neg;

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  assign req_rdy   = (state == IDLE);
  assign resp_val  = (state == DONE);
  assign req_go    = req_val & req_rdy;
  assign resp_go   = resp_val & resp_rdy;
  assign last_step = (count == `IMULDIV_CNT_W'(`IMULDIV_ITERS - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // step 32 lands in DONE, val shows the cycle after
          if (last_step) begin
            state <= DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        DONE: begin
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------

  // two's complement magnitude, -2^31 maps to 2^31 unsigned
  assign a_mag = req_msg.a[`IMULDIV_XLEN-1] ? -req_msg.a : req_msg.a;
  assign b_mag = req_msg.b[`IMULDIV_XLEN-1] ? -req_msg.b : req_msg.b;

  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand    <= {{`IMULDIV_XLEN{1'b0}}, a_mag};
      mplier   <= b_mag;
      acc      <= '0;
      prod_neg <= req_msg.a[`IMULDIV_XLEN-1] ^ req_msg.b[`IMULDIV_XLEN-1];
    end else if (state == CALC) begin
      // add when the current multiplier bit is set
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // restore the sign of the product
  assign resp_msg.result = prod_neg ? -acc : acc;

endmodule

//--- verilog/imuldiv_muldiv_iterative.sv
// imuldiv iterative multiply/divide unit, top level
// dispatcher, two engines and a response arbiter behind plain ports

`include "imuldiv_defines.svh"

module imuldiv_muldiv_iterative (
  input  logic                       clk,
  input  logic                       reset,

  // request
  input  logic [1:0]                 req_fn,
  input  logic [`IMULDIV_XLEN-1:0]   req_a,
  input  logic [`IMULDIV_XLEN-1:0]   req_b,
  input  logic                       req_val,
  output logic                       req_rdy,

  // response
  output logic [2*`IMULDIV_XLEN-1:0] resp_result,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  imuldiv_pkg::req_msg_t  req_msg;
  imuldiv_pkg::resp_msg_t resp_msg;

  logic                   mul_req_val;
  logic                   mul_req_rdy;
  logic                   div_req_val;
  logic                   div_req_rdy;

  imuldiv_pkg::resp_msg_t mul_resp_msg;
  logic                   mul_resp_val;
  logic                   mul_resp_rdy;
  imuldiv_pkg::resp_msg_t div_resp_msg;
  logic                   div_resp_val;
  logic                   div_resp_rdy;

  // ------------------------------------------------------------
  // message packing
  // ------------------------------------------------------------

  assign req_msg.fn  = imuldiv_pkg::fn_e'(req_fn);
  assign req_msg.a   = req_a;
  assign req_msg.b   = req_b;
  assign resp_result = resp_msg.result;

  // ------------------------------------------------------------
  // request side
  // ------------------------------------------------------------

  imuldiv_req_dispatch dispatch0 (
    .req_msg     (req_msg),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .mul_req_val (mul_req_val),
    .mul_req_rdy (mul_req_rdy),
    .div_req_val (div_req_val),
    .div_req_rdy (div_req_rdy)
  );

  // ------------------------------------------------------------
  // engines, both see the same request message
  // ------------------------------------------------------------

  imuldiv_mul_iterative mul0 (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_msg (mul_resp_msg),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  imuldiv_div_iterative div0 (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_msg (div_resp_msg),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy)
  );

  // ------------------------------------------------------------
  // response side
  // ------------------------------------------------------------

  imuldiv_resp_arbiter arb0 (
    .clk          (clk),
    .reset        (reset),
    .mul_resp_msg (mul_resp_msg),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .div_resp_msg (div_resp_msg),
    .div_resp_val (div_resp_val),
    .div_resp_rdy (div_resp_rdy),
    .resp_msg     (resp_msg),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy)
  );

endmodule

//--- verilog/imuldiv_pkg.sv
// imuldiv message types
// function codes and the request and response messages of every channel

`include "imuldiv_defines.svh"

package imuldiv_pkg;

  // ------------------------------------------------------------
  // function codes
  // ------------------------------------------------------------

  typedef enum logic [1:0] {
    // signed multiply, full 64-bit product
    FN_MUL  = 2'd0,
    // signed divide, remainder and quotient
    FN_DIV  = 2'd1,
    // unsigned divide
    FN_DIVU = 2'd2
  } fn_e;

  // ------------------------------------------------------------
  // messages
  // ------------------------------------------------------------

  // request, 66 bits
  typedef struct packed {
    fn_e                     fn;
    // dividend or multiplicand
    logic [`IMULDIV_XLEN-1:0] a;
    // divisor or multiplier
    logic [`IMULDIV_XLEN-1:0] b;
  } req_msg_t;

  // response, 64 bits
  // multiply gives the signed product
  // divide gives remainder in the upper half, quotient in the lower half
  typedef struct packed {
    logic [2*`IMULDIV_XLEN-1:0] result;
  } resp_msg_t;

endpackage

//--- verilog/imuldiv_req_dispatch.sv
// imuldiv request dispatcher
// steers a request to the multiplier or divider and returns that engine's ready

module imuldiv_req_dispatch (
  // incoming request channel
  input  imuldiv_pkg::req_msg_t req_msg,
  input  logic                  req_val,
  output logic                  req_rdy,

  // multiplier request side
  output logic                  mul_req_val,
  input  logic                  mul_req_rdy,

  // divider request side
  output logic                  div_req_val,
  input  logic                  div_req_rdy
);

  // ------------------------------------------------------------
  // decode
  // ------------------------------------------------------------

  // only multiply goes to the multiplier
  // both divide codes go to the divider
  logic sel_mul;

  assign sel_mul = (req_msg.fn == imuldiv_pkg::FN_MUL);

  // ------------------------------------------------------------
  // val and rdy steering
  // ------------------------------------------------------------

  // val reaches the selected engine only
  assign mul_req_val = req_val & sel_mul;
  assign div_req_val = req_val & ~sel_mul;

  // a busy target stalls the request even if the other engine is idle
  always_comb begin
    if (sel_mul) begin
      req_rdy = mul_req_rdy;
    end else begin
      req_rdy = div_req_rdy;
    end
  end

endmodule

//--- verilog/imuldiv_resp_arbiter.sv
// imuldiv response arbiter
// round-robin merge of the multiplier and divider responses onto one port

module imuldiv_resp_arbiter (
  input  logic                   clk,
  input  logic                   reset,

  // multiplier response side
  input  imuldiv_pkg::resp_msg_t mul_resp_msg,
  input  logic                   mul_resp_val,
  output logic                   mul_resp_rdy,

  // divider response side
  input  imuldiv_pkg::resp_msg_t div_resp_msg,
  input  logic                   div_resp_val,
  output logic                   div_resp_rdy,

  // merged response port
  output imuldiv_pkg::resp_msg_t resp_msg,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  // set when the divider wins a tie, i.e. the multiplier was served last
  logic prio_div;
  logic grant_mul;
  logic grant_div;
  logic resp_go;

  // ------------------------------------------------------------
  // grant
  // ------------------------------------------------------------

  // a lone requester always wins
  assign grant_div = div_resp_val & (~mul_resp_val | prio_div);
  assign grant_mul = mul_resp_val & ~grant_div;

  assign resp_val     = grant_mul | grant_div;
  assign resp_go      = resp_val & resp_rdy;
  assign mul_resp_rdy = resp_rdy & grant_mul;
  assign div_resp_rdy = resp_rdy & grant_div;

  // granted message out, no extra cycle
  assign resp_msg = grant_div ? div_resp_msg : mul_resp_msg;

  // ------------------------------------------------------------
  // pointer
  // ------------------------------------------------------------

  // moves only on a completed transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      prio_div <= 1'b0;
    end else if (resp_go) begin
      prio_div <= grant_mul;
    end
  end

endmodule
